// File: source/axi_pkg.sv
`default_nettype none

package axi_pkg;

    // read channel widths
    localparam int unsigned AXI_ID_W   = 4;
    localparam int unsigned AXI_ADDR_W = 10;
    localparam int unsigned AXI_DATA_W = 64;

    // one table entry per ARID value
    localparam int unsigned NUM_IDS = 1 << AXI_ID_W;

    typedef logic [AXI_ID_W-1:0]   axi_id_t;
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [7:0]            axi_len_t;
    typedef logic [2:0]            axi_size_t;
    typedef logic [1:0]            axi_burst_t;
    typedef logic [1:0]            axi_resp_t;

    // read address channel payload
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } ar_chan_t;

    // read data channel payload
    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } r_chan_t;

endpackage

`default_nettype wire

// File: source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef logic [7:0] lsu_tag_t;
    typedef logic [2:0] stride_code_t;
    typedef logic [1:0] elem_idx_t;

    // stride is 16 << code up to this code, zero above it
    localparam stride_code_t STRIDE_CODE_MAX   = 3'd4;
    localparam int unsigned  STRIDE_UNIT_SHIFT = 4;

    typedef struct packed {
        lsu_tag_t           tag;
        axi_pkg::axi_addr_t  addr;
        axi_pkg::axi_len_t   len;
        axi_pkg::axi_size_t  size;
        axi_pkg::axi_burst_t burst;
        stride_code_t        stride;
    } lsu_req_t;

    typedef struct packed {
        lsu_tag_t           tag;
        elem_idx_t          elem;
        axi_pkg::axi_data_t data;
        axi_pkg::axi_resp_t resp;
        logic               last;
    } lsu_resp_t;

    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_SEND
    } issue_state_t;

endpackage

`default_nettype wire

// File: source/ar_issue_fsm.sv
`default_nettype none

module ar_issue_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_vld,
    output logic                req_rdy,
    input  lsu_pkg::lsu_req_t   req,
    output logic                arvalid,
    input  logic                arready,
    output axi_pkg::ar_chan_t   ar,
    input  axi_pkg::axi_addr_t  cur_addr,
    input  logic                last_elem,
    input  logic                id_busy,
    output logic                load_req,
    output logic                step,
    output logic                alloc,
    output axi_pkg::axi_id_t    alloc_id,
    output lsu_pkg::lsu_tag_t   alloc_tag,
    output lsu_pkg::elem_idx_t  alloc_elem
);

    lsu_pkg::issue_state_t state;
    lsu_pkg::issue_state_t state_nxt;

    axi_pkg::axi_id_t    arid;
    lsu_pkg::elem_idx_t  elem_q;
    lsu_pkg::lsu_tag_t   tag_q;
    axi_pkg::axi_len_t   len_q;
    axi_pkg::axi_size_t  size_q;
    axi_pkg::axi_burst_t burst_q;

    logic ar_hs;

    assign req_rdy  = (state == lsu_pkg::ISSUE_IDLE);
    assign load_req = req_vld & req_rdy;

    // hold off while the next ID still has beats outstanding
    assign arvalid = (state == lsu_pkg::ISSUE_SEND) & ~id_busy;
    assign ar_hs   = arvalid & arready;

    assign step       = ar_hs;
    assign alloc      = ar_hs;
    assign alloc_id   = arid;
    assign alloc_tag  = tag_q;
    assign alloc_elem = elem_q;

    assign ar.id    = arid;
    assign ar.addr  = cur_addr;
    assign ar.len   = len_q;
    assign ar.size  = size_q;
    assign ar.burst = burst_q;

    always_comb begin
        state_nxt = state;
        case (state)
            lsu_pkg::ISSUE_IDLE: begin
                if (load_req) begin
                    state_nxt = lsu_pkg::ISSUE_SEND;
                end
            end
            lsu_pkg::ISSUE_SEND: begin
                if (ar_hs && last_elem) begin
                    state_nxt = lsu_pkg::ISSUE_IDLE;
                end
            end
            default: state_nxt = lsu_pkg::ISSUE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= lsu_pkg::ISSUE_IDLE;
            arid   <= '0;
            elem_q <= '0;
        end else begin
            state <= state_nxt;
            // rolling id, wraps after 15
            if (ar_hs) begin
                arid <= arid + 1'b1;
            end
            if (load_req) begin
                elem_q <= '0;
            end else if (ar_hs) begin
                elem_q <= elem_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_req) begin
            tag_q   <= req.tag;
            len_q   <= req.len;
            size_q  <= req.size;
            burst_q <= req.burst;
        end
    end

endmodule

`default_nettype wire

// File: source/stride_addr_gen.sv
`default_nettype none

module stride_addr_gen (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_req,
    input  logic                  step,
    input  axi_pkg::axi_addr_t    base_addr,
    input  axi_pkg::axi_size_t    size,
    input  lsu_pkg::stride_code_t stride,
    output axi_pkg::axi_addr_t    cur_addr,
    output lsu_pkg::elem_idx_t    elem,
    output logic                  last_elem
);

    axi_pkg::axi_addr_t stride_bytes;
    axi_pkg::axi_addr_t stride_q;
    lsu_pkg::elem_idx_t last_idx;
    lsu_pkg::elem_idx_t last_idx_q;
    lsu_pkg::elem_idx_t cnt;

    // codes above the max give a zero stride
    assign stride_bytes = (stride <= lsu_pkg::STRIDE_CODE_MAX)
                        ? axi_pkg::axi_addr_t'(1) << (lsu_pkg::STRIDE_UNIT_SHIFT + stride)
                        : '0;

    // 1, 2 or 4 elements, stored as the last index
    always_comb begin
        if (!size[2]) begin
            last_idx = 2'd0;
        end else if (size[0]) begin
            last_idx = 2'd3;
        end else begin
            last_idx = 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt        <= '0;
            last_idx_q <= '0;
        end else if (load_req) begin
            cnt        <= '0;
            last_idx_q <= last_idx;
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_req) begin
            cur_addr <= base_addr;
            stride_q <= stride_bytes;
        end else if (step) begin
            // 10-bit sum wraps modulo 1024
            cur_addr <= cur_addr + stride_q;
        end
    end

    assign elem      = cnt;
    assign last_elem = (cnt == last_idx_q);

endmodule

`default_nettype wire

// File: source/rid_map.sv
`default_nettype none

module rid_map (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alloc,
    input  axi_pkg::axi_id_t   alloc_id,
    input  lsu_pkg::lsu_tag_t  alloc_tag,
    input  lsu_pkg::elem_idx_t alloc_elem,
    output logic               id_busy,
    input  axi_pkg::axi_id_t   lookup_id,
    output lsu_pkg::lsu_tag_t  lookup_tag,
    output lsu_pkg::elem_idx_t lookup_elem,
    input  logic               id_release
);

    logic [axi_pkg::NUM_IDS-1:0] busy;
    lsu_pkg::lsu_tag_t           tag_mem  [axi_pkg::NUM_IDS];
    lsu_pkg::elem_idx_t          elem_mem [axi_pkg::NUM_IDS];

    assign id_busy     = busy[alloc_id];
    assign lookup_tag  = tag_mem[lookup_id];
    assign lookup_elem = elem_mem[lookup_id];

    // alloc only hits a free id and release only a busy one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (id_release) begin
                busy[lookup_id] <= 1'b0;
            end
            if (alloc) begin
                busy[alloc_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_mem[alloc_id]  <= alloc_tag;
            elem_mem[alloc_id] <= alloc_elem;
        end
    end

endmodule

`default_nettype wire

// File: source/r_resp_buffer.sv
`default_nettype none

module r_resp_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::r_chan_t   r,
    input  logic               rvalid,
    output logic               rready,
    output axi_pkg::axi_id_t   lookup_id,
    input  lsu_pkg::lsu_tag_t  lookup_tag,
    input  lsu_pkg::elem_idx_t lookup_elem,
    output logic               id_release,
    output lsu_pkg::lsu_resp_t resp,
    output logic               resp_vld,
    input  logic               resp_rdy
);

    logic r_hs;

    // single slot, so R stalls whenever it is full
    assign rready = ~resp_vld;
    assign r_hs   = rvalid & rready;

    assign lookup_id = r.id;

    // frees the id once its final beat is taken
    assign id_release = r_hs & r.last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_vld <= 1'b0;
        end else if (r_hs) begin
            resp_vld <= 1'b1;
        end else if (resp_rdy) begin
            resp_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (r_hs) begin
            resp.tag  <= lookup_tag;
            resp.elem <= lookup_elem;
            resp.data <= r.data;
            // rresp goes through unchanged
            resp.resp <= r.resp;
            resp.last <= r.last;
        end
    end

endmodule

`default_nettype wire

// File: source/axi_read_intf.sv
`default_nettype none

module axi_read_intf (
    input  logic               clk,
    input  logic               rst_n,
    // lsu request
    input  logic               req_vld,
    output logic               req_rdy,
    input  lsu_pkg::lsu_req_t  req,
    // axi read address
    output axi_pkg::ar_chan_t  ar,
    output logic               arvalid,
    input  logic               arready,
    // axi read data
    input  axi_pkg::r_chan_t   r,
    input  logic               rvalid,
    output logic               rready,
    // lsu response
    output lsu_pkg::lsu_resp_t resp,
    output logic               resp_vld,
    input  logic               resp_rdy
);

    logic               load_req;
    logic               step;
    axi_pkg::axi_addr_t cur_addr;
    logic               last_elem;

    logic               alloc;
    axi_pkg::axi_id_t   alloc_id;
    lsu_pkg::lsu_tag_t  alloc_tag;
    lsu_pkg::elem_idx_t alloc_elem;
    logic               id_busy;

    axi_pkg::axi_id_t   lookup_id;
    lsu_pkg::lsu_tag_t  lookup_tag;
    lsu_pkg::elem_idx_t lookup_elem;
    logic               id_release;

    ar_issue_fsm u_ar_issue_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_vld    (req_vld),
        .req_rdy    (req_rdy),
        .req        (req),
        .arvalid    (arvalid),
        .arready    (arready),
        .ar         (ar),
        .cur_addr   (cur_addr),
        .last_elem  (last_elem),
        .id_busy    (id_busy),
        .load_req   (load_req),
        .step       (step),
        .alloc      (alloc),
        .alloc_id   (alloc_id),
        .alloc_tag  (alloc_tag),
        .alloc_elem (alloc_elem)
    );

    // element index is tracked by the fsm for the id table
    stride_addr_gen u_stride_addr_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_req  (load_req),
        .step      (step),
        .base_addr (req.addr),
        .size      (req.size),
        .stride    (req.stride),
        .cur_addr  (cur_addr),
        .elem      (),
        .last_elem (last_elem)
    );

    rid_map u_rid_map (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc       (alloc),
        .alloc_id    (alloc_id),
        .alloc_tag   (alloc_tag),
        .alloc_elem  (alloc_elem),
        .id_busy     (id_busy),
        .lookup_id   (lookup_id),
        .lookup_tag  (lookup_tag),
        .lookup_elem (lookup_elem),
        .id_release  (id_release)
    );

    r_resp_buffer u_r_resp_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .lookup_id   (lookup_id),
        .lookup_tag  (lookup_tag),
        .lookup_elem (lookup_elem),
        .id_release  (id_release),
        .resp        (resp),
        .resp_vld    (resp_vld),
        .resp_rdy    (resp_rdy)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_axi_mem.sv
`default_nettype none

module tb_axi_mem #(
    parameter int SEED = 32'h77c2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              slow,
    input  axi_pkg::ar_chan_t ar,
    input  logic              arvalid,
    output logic              arready,
    output axi_pkg::r_chan_t  r,
    output logic              rvalid,
    input  logic              rready
);

    axi_pkg::ar_chan_t ar_q[$];
    axi_pkg::ar_chan_t cur;
    axi_pkg::axi_len_t beat;
    integer            seed;
    int                gap;
    logic              r_taken;

    // everything runs on the falling edge, handshakes land on the next rising edge
    initial begin
        seed    = SEED;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        beat    = '0;
        gap     = 0;
        r_taken = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                arready = 1'b0;
                rvalid  = 1'b0;
                beat    = '0;
                gap     = 0;
                r_taken = 1'b0;
                ar_q.delete();
            end else begin
                // retire the beat taken at the last rising edge
                if (r_taken) begin
                    rvalid = 1'b0;
                    if (beat == ar_q[0].len) begin
                        void'(ar_q.pop_front());
                        beat = '0;
                    end else begin
                        beat = beat + 1'b1;
                    end
                    if (slow) begin
                        gap = int'($unsigned($random(seed)) % 16);
                    end else begin
                        gap = int'($unsigned($random(seed)) % 3);
                    end
                end
                if (!rvalid) begin
                    if (gap > 0) begin
                        gap = gap - 1;
                    end else if (ar_q.size() != 0) begin
                        cur    = ar_q[0];
                        r.id   = cur.id;
                        r.data = {36'd0, cur.addr, beat, ~cur.addr};
                        // top quarter of the map answers with slverr
                        r.resp = (cur.addr[9:8] == 2'b11) ? 2'b10 : 2'b00;
                        r.last = (beat == cur.len);
                        rvalid = 1'b1;
                    end
                end
                r_taken = rvalid & rready;
                // AR after R so a new burst never answers in its own cycle
                arready = ($unsigned($random(seed)) % 4) != 0;
                if (arvalid && arready) begin
                    ar_q.push_back(ar);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_axi_read_intf.sv
`default_nettype none

module tb_axi_read_intf;

    logic               clk;
    logic               rst_n;
    logic               req_vld;
    logic               req_rdy;
    lsu_pkg::lsu_req_t  req;
    axi_pkg::ar_chan_t  ar;
    logic               arvalid;
    logic               arready;
    axi_pkg::r_chan_t   r;
    logic               rvalid;
    logic               rready;
    lsu_pkg::lsu_resp_t resp;
    logic               resp_vld;
    logic               resp_rdy = 1'b0;

    logic               stall_en = 1'b0;
    logic               slow = 1'b0;
    integer             seed = 32'h77c2;

    lsu_pkg::lsu_req_t  req_list[$];
    int                 test_of[$];
    lsu_pkg::lsu_resp_t exp_q[$];
    lsu_pkg::lsu_resp_t exp_beat;
    axi_pkg::ar_chan_t  ar_exp_q[$];
    axi_pkg::ar_chan_t  exp_ar;
    lsu_pkg::lsu_tag_t  next_tag = '0;
    int                 total_beats = 0;
    int                 cycle_limit = 0;
    int                 cycle_cnt;
    int                 err_cnt = 0;
    int                 pass_tests = 0;
    int                 fail_tests = 0;

    tb_clk_gen #(.PERIOD(8), .RST_CYCLES(5)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axi_read_intf u_axi_read_intf (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_vld  (req_vld),
        .req_rdy  (req_rdy),
        .req      (req),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .r        (r),
        .rvalid   (rvalid),
        .rready   (rready),
        .resp     (resp),
        .resp_vld (resp_vld),
        .resp_rdy (resp_rdy)
    );

    tb_axi_mem u_axi_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .slow    (slow),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int elem_count(input axi_pkg::axi_size_t size);
        case (size)
            3'd4, 3'd6: return 2;
            3'd5, 3'd7: return 4;
            default:    return 1;
        endcase
    endfunction

    function automatic int stride_of(input lsu_pkg::stride_code_t code);
        if (code <= 3'd4) begin
            return 16 << code;
        end else begin
            return 0;
        end
    endfunction

    function automatic int beat_count(input lsu_pkg::lsu_req_t rq);
        return elem_count(rq.size) * (int'(rq.len) + 1);
    endfunction

    // expected AR payloads and beats of one request, in the order the bridge issues them
    function automatic void ref_expand(input lsu_pkg::lsu_req_t rq);
        lsu_pkg::lsu_resp_t b;
        axi_pkg::ar_chan_t  a;
        axi_pkg::axi_addr_t ea;
        int                 n_elem;
        int                 step_b;
        n_elem = elem_count(rq.size);
        step_b = stride_of(rq.stride);
        for (int e = 0; e < n_elem; e++) begin
            ea = axi_pkg::axi_addr_t'((int'(rq.addr) + e * step_b) % 1024);
            a.addr  = ea;
            a.len   = rq.len;
            a.size  = rq.size;
            a.burst = rq.burst;
            ar_exp_q.push_back(a);
            for (int k = 0; k <= int'(rq.len); k++) begin
                b.tag  = rq.tag;
                b.elem = lsu_pkg::elem_idx_t'(e);
                b.data = {36'd0, ea, axi_pkg::axi_len_t'(k), ~ea};
                b.resp = (int'(ea) >= 768) ? 2'b10 : 2'b00;
                b.last = (k == int'(rq.len));
                exp_q.push_back(b);
            end
        end
    endfunction

    function automatic void add_req(input int t, input int addr, input int len,
                                    input int size, input int code);
        lsu_pkg::lsu_req_t rq;
        rq.tag    = next_tag;
        rq.addr   = axi_pkg::axi_addr_t'(addr);
        rq.len    = axi_pkg::axi_len_t'(len);
        rq.size   = axi_pkg::axi_size_t'(size);
        // fixed or incr
        rq.burst  = axi_pkg::axi_burst_t'(rnd(2));
        rq.stride = lsu_pkg::stride_code_t'(code);
        next_tag  = next_tag + 1'b1;
        req_list.push_back(rq);
        test_of.push_back(t);
        total_beats = total_beats + beat_count(rq);
    endfunction

    function automatic void build_requests();
        for (int i = 0; i < 6; i++) begin
            add_req(1, rnd(768), rnd(4), rnd(4), rnd(8));
        end
        for (int sz = 4; sz < 8; sz++) begin
            for (int code = 0; code < 8; code++) begin
                add_req(2, rnd(768), rnd(2), sz, code);
            end
        end
        // bases near the top so strided elements wrap
        for (int i = 0; i < 6; i++) begin
            add_req(3, 960 + rnd(64), rnd(2), (rnd(2) == 0) ? 5 : 7, 2 + rnd(3));
        end
        // 32 elements back to back, more than there are ids
        for (int i = 0; i < 8; i++) begin
            add_req(4, rnd(768), 1, 7, rnd(5));
        end
        for (int i = 0; i < 12; i++) begin
            add_req(5, rnd(1024), rnd(4), rnd(8), rnd(8));
        end
        // zero stride keeps every element in the top quarter
        for (int i = 0; i < 6; i++) begin
            add_req(6, 768 + rnd(256), rnd(4), rnd(8), 5 + rnd(3));
        end
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h, expected %h", $time, name, got, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    // called on a falling edge, returns on the falling edge after the handshake
    task automatic send_req(input lsu_pkg::lsu_req_t rq);
        req     = rq;
        req_vld = 1'b1;
        while (!req_rdy) begin
            @(negedge clk);
        end
        @(negedge clk);
        ref_expand(rq);
        req_vld = 1'b0;
    endtask

    task automatic run_test(input int t, input string name);
        int errs_before;
        int n_beats;
        errs_before = err_cnt;
        n_beats     = 0;
        foreach (req_list[i]) begin
            if (test_of[i] == t) begin
                n_beats = n_beats + beat_count(req_list[i]);
                send_req(req_list[i]);
            end
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        if (err_cnt == errs_before) begin
            pass_tests = pass_tests + 1;
            $display("test %0d %s: %0d beats, ok", t, name, n_beats);
        end else begin
            fail_tests = fail_tests + 1;
            $display("test %0d %s: %0d beats, %0d errors", t, name, n_beats,
                     err_cnt - errs_before);
        end
    endtask

    // values seen here are the ones the handshake at this edge takes
    always @(posedge clk) begin
        if (rst_n && arvalid && arready) begin
            if (ar_exp_q.size() == 0) begin
                $display("Error at time %0t: AR handshake when no element was due", $time);
                err_cnt = err_cnt + 1;
            end else begin
                exp_ar = ar_exp_q.pop_front();
                check_val("ar.addr", 64'(ar.addr), 64'(exp_ar.addr));
                check_val("ar.len", 64'(ar.len), 64'(exp_ar.len));
                check_val("ar.size", 64'(ar.size), 64'(exp_ar.size));
                check_val("ar.burst", 64'(ar.burst), 64'(exp_ar.burst));
            end
        end
    end

    // resp_rdy is set here, so a handshake on the next rising edge is known now
    always @(negedge clk) begin
        if (rst_n) begin
            if (stall_en) begin
                resp_rdy = ($unsigned($random(seed)) % 4) != 0;
            end else begin
                resp_rdy = 1'b1;
            end
            if (resp_vld && resp_rdy) begin
                if (exp_q.size() == 0) begin
                    $display("Error at time %0t: response beat with tag %h arrived when none was due",
                             $time, resp.tag);
                    err_cnt = err_cnt + 1;
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_val("resp.tag", 64'(resp.tag), 64'(exp_beat.tag));
                    check_val("resp.elem", 64'(resp.elem), 64'(exp_beat.elem));
                    check_val("resp.data", resp.data, exp_beat.data);
                    check_val("resp.resp", 64'(resp.resp), 64'(exp_beat.resp));
                    check_val("resp.last", 64'(resp.last), 64'(exp_beat.last));
                end
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout: run stopped after %0d cycles with %0d response beats still missing",
                 cycle_limit, exp_q.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        req_vld = 1'b0;
        req     = '0;
        build_requests();
        cycle_limit = 40 * total_beats + 200;
        wait (rst_n === 1'b1);
        @(negedge clk);
        run_test(1, "single element");
        run_test(2, "size and stride");
        run_test(3, "address wrap");
        slow = 1'b1;
        run_test(4, "id reuse");
        slow     = 1'b0;
        stall_en = 1'b1;
        run_test(5, "response stalls");
        stall_en = 1'b0;
        run_test(6, "slverr range");
        // catch stray beats after the last test
        repeat (20) @(negedge clk);
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_tests, fail_tests, err_cnt);
        if (fail_tests == 0 && err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: axi_read_intf.f
source/axi_pkg.sv
source/lsu_pkg.sv
source/ar_issue_fsm.sv
source/stride_addr_gen.sv
source/rid_map.sv
source/r_resp_buffer.sv
source/axi_read_intf.sv
testbench/tb_clk_gen.sv
testbench/tb_axi_mem.sv
testbench/tb_axi_read_intf.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

top=tb_axi_read_intf
log=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module "$top" \
        -f axi_read_intf.f -o "sim_$top"; then
    echo "verilator build error"
    exit 1
fi

./obj_dir/"sim_$top" > "$log" 2>&1
run_status=$?
cat "$log"

if [ "$run_status" -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    echo "testbench reported a failure"
    exit 1
fi

if ! grep -q "Simulation completed successfully" "$log"; then
    echo "no pass line found in $log"
    exit 1
fi

exit 0
